// ==== rtl/issue_consts.svh ====
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// --------------------------------------------------
// datapath sizes
// --------------------------------------------------
// integer data word
`define ISSUE_XLEN 64
// architectural integer registers
`define ISSUE_NR_REGS 32
// register address width
`define ISSUE_REG_ADDR_W 5

// --------------------------------------------------
// scoreboard and commit
// --------------------------------------------------
// write ports coming back from commit
`define ISSUE_NR_COMMIT 2
// scoreboard transaction id width
`define ISSUE_TRANS_ID_W 3
// csr zero-extended immediate, lives in the rs1 field
`define ISSUE_ZIMM_W 5

`endif

// ==== rtl/issue_pkg.sv ====
package issue_pkg;

    `include "issue_consts.svh"

    // --------------------------------------------------
    // width types
    // --------------------------------------------------
    typedef logic [`ISSUE_XLEN-1:0]       xlen_t;
    typedef logic [`ISSUE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ISSUE_TRANS_ID_W-1:0] trans_id_t;

    // --------------------------------------------------
    // functional units
    // --------------------------------------------------
    // in the clobber list NONE means no writer in flight
    typedef enum logic [2:0] {
        NONE,
        LOAD,
        STORE,
        ALU,
        CTRL_FLOW,
        MULT,
        CSR
    } fu_e;

    // operators, only carried through to execute
    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL,
        LD, SD,
        BEQ, JALR,
        MUL,
        CSRRW
    } fu_op_e;

endpackage

// ==== rtl/int_regfile.sv ====
`include "issue_consts.svh"

module int_regfile
    import issue_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_ni,
    // combinational read ports
    input  reg_addr_t                           raddr_a_i,
    input  reg_addr_t                           raddr_b_i,
    output xlen_t                               rdata_a_o,
    output xlen_t                               rdata_b_o,
    // commit write ports
    input  logic [`ISSUE_NR_COMMIT-1:0]         commit_we_i,
    input  reg_addr_t [`ISSUE_NR_COMMIT-1:0]    commit_waddr_i,
    input  xlen_t [`ISSUE_NR_COMMIT-1:0]        commit_wdata_i
);

    // x0 has no storage
    xlen_t mem_q [1:`ISSUE_NR_REGS-1];

    // --------------------------------------------------
    // write
    // --------------------------------------------------
    // later ports overwrite earlier ones on an address clash
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int r = 1; r < `ISSUE_NR_REGS; r++) begin
                mem_q[r] <= '0;
            end
        end else begin
            for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
                // writes to x0 are dropped
                if (commit_we_i[p] && commit_waddr_i[p] != '0) begin
                    mem_q[commit_waddr_i[p]] <= commit_wdata_i[p];
                end
            end
        end
    end

    // --------------------------------------------------
    // read
    // --------------------------------------------------
    always_comb begin
        rdata_a_o = '0;
        rdata_b_o = '0;
        if (raddr_a_i != '0) begin
            rdata_a_o = mem_q[raddr_a_i];
        end
        if (raddr_b_i != '0) begin
            rdata_b_o = mem_q[raddr_b_i];
        end
    end

endmodule

// ==== rtl/issue_ctrl.sv ====
`include "issue_consts.svh"

module issue_ctrl
    import issue_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    // instruction from the scoreboard
    input  logic                                issue_valid_i,
    output logic                                issue_ack_o,
    input  fu_e                                 issue_fu_i,
    input  reg_addr_t                           issue_rs1_i,
    input  reg_addr_t                           issue_rs2_i,
    input  reg_addr_t                           issue_rd_i,
    input  logic                                issue_use_zimm_i,
    input  logic                                issue_ex_valid_i,
    // scoreboard lookup results
    input  logic                                sb_rs1_valid_i,
    input  logic                                sb_rs2_valid_i,
    input  fu_e [`ISSUE_NR_REGS-1:0]            rd_clobber_i,
    // commit write ports, only the enables and addresses matter here
    input  logic [`ISSUE_NR_COMMIT-1:0]         commit_we_i,
    input  reg_addr_t [`ISSUE_NR_COMMIT-1:0]    commit_waddr_i,
    // unit readiness
    input  logic                                flu_ready_i,
    input  logic                                lsu_ready_i,
    // forwarding selects toward the operand muxes
    output logic                                fwd_a_o,
    output logic                                fwd_b_o,
    // one-cycle unit valids
    output logic                                alu_valid_o,
    output logic                                branch_valid_o,
    output logic                                lsu_valid_o,
    output logic                                mult_valid_o,
    output logic                                csr_valid_o
);

    // youngest in-flight writer per register of interest
    fu_e  rs1_writer;
    fu_e  rs2_writer;
    fu_e  rd_writer;
    logic stall;
    logic fu_busy;
    logic waw_free;

    logic alu_valid_d,    alu_valid_q;
    logic branch_valid_d, branch_valid_q;
    logic lsu_valid_d,    lsu_valid_q;
    logic mult_valid_d,   mult_valid_q;
    logic csr_valid_d,    csr_valid_q;

    assign rs1_writer = rd_clobber_i[issue_rs1_i];
    assign rs2_writer = rd_clobber_i[issue_rs2_i];
    assign rd_writer  = rd_clobber_i[issue_rd_i];

    // --------------------------------------------------
    // operand availability
    // --------------------------------------------------
    always_comb begin
        stall   = 1'b0;
        fwd_a_o = 1'b0;
        fwd_b_o = 1'b0;
        // zimm sits in the rs1 field, nothing to wait for then
        if (!issue_use_zimm_i && rs1_writer != NONE) begin
            // csr results only reach us through the register file
            if (sb_rs1_valid_i && rs1_writer != CSR) begin
                fwd_a_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rs2_writer != NONE) begin
            if (sb_rs2_valid_i && rs2_writer != CSR) begin
                fwd_b_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // busy flag of the unit this instruction needs
    always_comb begin
        case (issue_fu_i)
            ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // write-after-write: rd free, or being written by commit right now
    always_comb begin
        waw_free = (rd_writer == NONE);
        for (int i = 0; i < `ISSUE_NR_COMMIT; i++) begin
            if (commit_we_i[i] && commit_waddr_i[i] == issue_rd_i) begin
                waw_free = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // accept decision
    // --------------------------------------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && waw_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less instructions just pass through
            if (issue_ex_valid_i || issue_fu_i == NONE) begin
                issue_ack_o = 1'b1;
            end
        end
        // the fixed latency bus only takes mult right behind a mult
        if (mult_valid_q && issue_fu_i != MULT) begin
            issue_ack_o = 1'b0;
        end
    end

    // unit valid decode, raised for the cycle after acceptance
    always_comb begin
        alu_valid_d    = 1'b0;
        branch_valid_d = 1'b0;
        lsu_valid_d    = 1'b0;
        mult_valid_d   = 1'b0;
        csr_valid_d    = 1'b0;
        if (issue_valid_i && issue_ack_o && !issue_ex_valid_i && !flush_i) begin
            case (issue_fu_i)
                ALU:         alu_valid_d    = 1'b1;
                CTRL_FLOW:   branch_valid_d = 1'b1;
                LOAD, STORE: lsu_valid_d    = 1'b1;
                MULT:        mult_valid_d   = 1'b1;
                CSR:         csr_valid_d    = 1'b1;
                default:     ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            alu_valid_q    <= 1'b0;
            branch_valid_q <= 1'b0;
            lsu_valid_q    <= 1'b0;
            mult_valid_q   <= 1'b0;
            csr_valid_q    <= 1'b0;
        end else begin
            alu_valid_q    <= alu_valid_d;
            branch_valid_q <= branch_valid_d;
            lsu_valid_q    <= lsu_valid_d;
            mult_valid_q   <= mult_valid_d;
            csr_valid_q    <= csr_valid_d;
        end
    end

    assign alu_valid_o    = alu_valid_q;
    assign branch_valid_o = branch_valid_q;
    assign lsu_valid_o    = lsu_valid_q;
    assign mult_valid_o   = mult_valid_q;
    assign csr_valid_o    = csr_valid_q;

endmodule

// ==== rtl/operand_select.sv ====
`include "issue_consts.svh"

module operand_select
    import issue_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    // forwarding selects from the control
    input  logic      fwd_a_i,
    input  logic      fwd_b_i,
    // register file and scoreboard values
    input  xlen_t     rf_a_i,
    input  xlen_t     rf_b_i,
    input  xlen_t     sb_rs1_data_i,
    input  xlen_t     sb_rs2_data_i,
    // instruction fields
    input  fu_e       issue_fu_i,
    input  fu_op_e    issue_op_i,
    input  reg_addr_t issue_rs1_i,
    input  xlen_t     issue_imm_i,
    input  xlen_t     issue_pc_i,
    input  trans_id_t issue_trans_id_i,
    input  reg_addr_t issue_rd_i,
    input  logic      issue_use_pc_i,
    input  logic      issue_use_imm_i,
    input  logic      issue_use_zimm_i,
    // execute-stage register outputs
    output xlen_t     operand_a_o,
    output xlen_t     operand_b_o,
    output xlen_t     imm_o,
    output xlen_t     pc_o,
    output fu_e       fu_o,
    output fu_op_e    operator_o,
    output trans_id_t trans_id_o,
    output reg_addr_t rd_o
);

    xlen_t operand_a_d;
    xlen_t operand_b_d;

    // --------------------------------------------------
    // operand muxes
    // --------------------------------------------------
    always_comb begin
        // scoreboard value wins over the register file
        operand_a_d = fwd_a_i ? sb_rs1_data_i : rf_a_i;
        operand_b_d = fwd_b_i ? sb_rs2_data_i : rf_b_i;
        // auipc, jal style: pc as operand a
        if (issue_use_pc_i) begin
            operand_a_d = issue_pc_i;
        end
        // csr immediate, zero extended
        if (issue_use_zimm_i) begin
            operand_a_d = {{(`ISSUE_XLEN-`ISSUE_ZIMM_W){1'b0}},
                           issue_rs1_i[`ISSUE_ZIMM_W-1:0]};
        end
        // stores and branches keep rs2 in b, their imm travels on imm_o
        if (issue_use_imm_i && issue_fu_i != STORE && issue_fu_i != CTRL_FLOW) begin
            operand_b_d = issue_imm_i;
        end
    end

    // --------------------------------------------------
    // issue to execute registers
    // --------------------------------------------------
    // loaded every cycle, the unit valid says when they count
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            operand_a_o <= '0;
            operand_b_o <= '0;
            imm_o       <= '0;
            pc_o        <= '0;
            fu_o        <= NONE;
            operator_o  <= ADD;
            trans_id_o  <= '0;
            rd_o        <= '0;
        end else begin
            operand_a_o <= operand_a_d;
            operand_b_o <= operand_b_d;
            imm_o       <= issue_imm_i;
            pc_o        <= issue_pc_i;
            fu_o        <= issue_fu_i;
            operator_o  <= issue_op_i;
            trans_id_o  <= issue_trans_id_i;
            rd_o        <= issue_rd_i;
        end
    end

endmodule

// ==== rtl/issue_read_operands.sv ====
`include "issue_consts.svh"

module issue_read_operands
    import issue_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    // instruction from the scoreboard
    input  logic                                issue_valid_i,
    output logic                                issue_ack_o,
    input  fu_e                                 issue_fu_i,
    input  fu_op_e                              issue_op_i,
    input  reg_addr_t                           issue_rs1_i,
    input  reg_addr_t                           issue_rs2_i,
    input  reg_addr_t                           issue_rd_i,
    input  xlen_t                               issue_imm_i,
    input  xlen_t                               issue_pc_i,
    input  trans_id_t                           issue_trans_id_i,
    input  logic                                issue_use_pc_i,
    input  logic                                issue_use_imm_i,
    input  logic                                issue_use_zimm_i,
    input  logic                                issue_ex_valid_i,
    // scoreboard operand lookup
    output reg_addr_t                           sb_rs1_addr_o,
    output reg_addr_t                           sb_rs2_addr_o,
    input  xlen_t                               sb_rs1_data_i,
    input  logic                                sb_rs1_valid_i,
    input  xlen_t                               sb_rs2_data_i,
    input  logic                                sb_rs2_valid_i,
    input  fu_e [`ISSUE_NR_REGS-1:0]            rd_clobber_i,
    // commit
    input  logic [`ISSUE_NR_COMMIT-1:0]         commit_we_i,
    input  reg_addr_t [`ISSUE_NR_COMMIT-1:0]    commit_waddr_i,
    input  xlen_t [`ISSUE_NR_COMMIT-1:0]        commit_wdata_i,
    // unit readiness
    input  logic                                flu_ready_i,
    input  logic                                lsu_ready_i,
    // toward execute
    output xlen_t                               operand_a_o,
    output xlen_t                               operand_b_o,
    output xlen_t                               imm_o,
    output xlen_t                               pc_o,
    output fu_e                                 fu_o,
    output fu_op_e                              operator_o,
    output trans_id_t                           trans_id_o,
    output reg_addr_t                           rd_o,
    output logic                                alu_valid_o,
    output logic                                branch_valid_o,
    output logic                                lsu_valid_o,
    output logic                                mult_valid_o,
    output logic                                csr_valid_o
);

    // forwarding selects and register file data
    logic  fwd_a;
    logic  fwd_b;
    xlen_t rf_a;
    xlen_t rf_b;

    // scoreboard is polled with the source fields as they are
    assign sb_rs1_addr_o = issue_rs1_i;
    assign sb_rs2_addr_o = issue_rs2_i;

    issue_ctrl i_issue_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .issue_valid_i    (issue_valid_i),
        .issue_ack_o      (issue_ack_o),
        .issue_fu_i       (issue_fu_i),
        .issue_rs1_i      (issue_rs1_i),
        .issue_rs2_i      (issue_rs2_i),
        .issue_rd_i       (issue_rd_i),
        .issue_use_zimm_i (issue_use_zimm_i),
        .issue_ex_valid_i (issue_ex_valid_i),
        .sb_rs1_valid_i   (sb_rs1_valid_i),
        .sb_rs2_valid_i   (sb_rs2_valid_i),
        .rd_clobber_i     (rd_clobber_i),
        .commit_we_i      (commit_we_i),
        .commit_waddr_i   (commit_waddr_i),
        .flu_ready_i      (flu_ready_i),
        .lsu_ready_i      (lsu_ready_i),
        .fwd_a_o          (fwd_a),
        .fwd_b_o          (fwd_b),
        .alu_valid_o      (alu_valid_o),
        .branch_valid_o   (branch_valid_o),
        .lsu_valid_o      (lsu_valid_o),
        .mult_valid_o     (mult_valid_o),
        .csr_valid_o      (csr_valid_o)
    );

    int_regfile i_int_regfile (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .raddr_a_i      (issue_rs1_i),
        .raddr_b_i      (issue_rs2_i),
        .rdata_a_o      (rf_a),
        .rdata_b_o      (rf_b),
        .commit_we_i    (commit_we_i),
        .commit_waddr_i (commit_waddr_i),
        .commit_wdata_i (commit_wdata_i)
    );

    operand_select i_operand_select (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .fwd_a_i          (fwd_a),
        .fwd_b_i          (fwd_b),
        .rf_a_i           (rf_a),
        .rf_b_i           (rf_b),
        .sb_rs1_data_i    (sb_rs1_data_i),
        .sb_rs2_data_i    (sb_rs2_data_i),
        .issue_fu_i       (issue_fu_i),
        .issue_op_i       (issue_op_i),
        .issue_rs1_i      (issue_rs1_i),
        .issue_imm_i      (issue_imm_i),
        .issue_pc_i       (issue_pc_i),
        .issue_trans_id_i (issue_trans_id_i),
        .issue_rd_i       (issue_rd_i),
        .issue_use_pc_i   (issue_use_pc_i),
        .issue_use_imm_i  (issue_use_imm_i),
        .issue_use_zimm_i (issue_use_zimm_i),
        .operand_a_o      (operand_a_o),
        .operand_b_o      (operand_b_o),
        .imm_o            (imm_o),
        .pc_o             (pc_o),
        .fu_o             (fu_o),
        .operator_o       (operator_o),
        .trans_id_o       (trans_id_o),
        .rd_o             (rd_o)
    );

endmodule

// ==== bench/tb_issue_vectors.svh ====
`ifndef TB_ISSUE_VECTORS_SVH
`define TB_ISSUE_VECTORS_SVH

// where the expected operand value comes from
typedef enum logic [2:0] {
    S_RF,
    S_FWD,
    S_PC,
    S_ZIMM,
    S_IMM
} src_e;

// one row per clock cycle
typedef struct packed {
    logic       valid;
    fu_e        fu;
    fu_op_e     op;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic       use_pc;
    logic       use_imm;
    logic       use_zimm;
    logic       ex;
    // youngest in-flight writer of rs1, rs2 and rd
    fu_e        clob_rs1;
    fu_e        clob_rs2;
    fu_e        clob_rd;
    logic       sb1_valid;
    logic       sb2_valid;
    // commit write enables and addresses, data comes from the lcg
    logic [1:0] commit_en;
    reg_addr_t  commit_addr0;
    reg_addr_t  commit_addr1;
    logic       flu_ready;
    logic       lsu_ready;
    logic       flush;
    // expected ack, unit that pulses next cycle, operand sources
    logic       exp_ack;
    fu_e        exp_pulse;
    src_e       exp_a;
    src_e       exp_b;
} row_t;

localparam int N_ROWS = 24;

// columns: valid fu op rs1 rs2 rd | pc imm zimm ex | clob rs1 rs2 rd | sb valids
//          | commit en a0 a1 | flu lsu flush | ack pulse a b
localparam row_t VECTORS [N_ROWS] = '{
    // fill x1, x2, then x3 on both ports
    '{0,NONE,ADD,0,0,0, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b11,1,2, 1,1,0, 0,NONE,S_RF,S_RF},
    '{0,NONE,ADD,0,0,0, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b11,3,3, 1,1,0, 0,NONE,S_RF,S_RF},
    // plain register reads, x0 reads zero
    '{1,ALU,ADD,1,2,5, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 1,ALU,S_RF,S_RF},
    '{1,ALU,OR,3,0,6, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 1,ALU,S_RF,S_RF},
    // forwarding, then stalls
    '{1,ALU,SUB,1,2,7, 0,0,0,0, ALU,LOAD,NONE, 1,1, 2'b00,0,0, 1,1,0, 1,ALU,S_FWD,S_FWD},
    '{1,ALU,ADD,1,2,7, 0,0,0,0, ALU,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 0,NONE,S_RF,S_RF},
    '{1,ALU,ADD,1,2,7, 0,0,0,0, NONE,CSR,NONE, 0,1, 2'b00,0,0, 1,1,0, 0,NONE,S_RF,S_RF},
    // operand muxing
    '{1,ALU,ADD,4,0,10, 1,1,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 1,ALU,S_PC,S_IMM},
    '{1,CSR,CSRRW,21,0,9, 0,0,1,0, ALU,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 1,CSR,S_ZIMM,S_RF},
    '{1,STORE,SD,1,2,0, 0,1,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 1,STORE,S_RF,S_RF},
    // waw block and release by commit
    '{1,ALU,AND,1,2,8, 0,0,0,0, NONE,NONE,ALU, 0,0, 2'b00,0,0, 1,1,0, 0,NONE,S_RF,S_RF},
    '{1,ALU,AND,1,2,8, 0,0,0,0, NONE,NONE,ALU, 0,0, 2'b10,0,8, 1,1,0, 1,ALU,S_RF,S_RF},
    // busy units
    '{1,LOAD,LD,1,0,11, 0,1,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,0,0, 0,NONE,S_RF,S_IMM},
    '{1,ALU,ADD,1,2,11, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 0,1,0, 0,NONE,S_RF,S_RF},
    // exception, no unit, flush
    '{1,ALU,ADD,1,2,11, 0,0,0,1, NONE,NONE,NONE, 0,0, 2'b00,0,0, 0,1,0, 1,NONE,S_RF,S_RF},
    '{1,NONE,ADD,3,8,0, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 0,0,0, 1,NONE,S_RF,S_RF},
    '{1,ALU,SUB,1,3,12, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,1,1, 1,NONE,S_RF,S_RF},
    // mult behind mult ok, alu behind mult refused
    '{1,MULT,MUL,3,8,13, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 1,MULT,S_RF,S_RF},
    '{1,MULT,MUL,1,2,14, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 1,MULT,S_RF,S_RF},
    '{1,ALU,XOR,1,2,15, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 0,NONE,S_RF,S_RF},
    '{1,ALU,XOR,8,1,15, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 1,ALU,S_RF,S_RF},
    // write to x0 is dropped
    '{0,NONE,ADD,0,0,0, 0,0,0,0, NONE,NONE,NONE, 0,0, 2'b01,0,0, 1,1,0, 0,NONE,S_RF,S_RF},
    '{1,LOAD,LD,0,3,16, 0,1,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 1,LOAD,S_RF,S_IMM},
    '{1,CTRL_FLOW,BEQ,1,2,0, 0,1,0,0, NONE,NONE,NONE, 0,0, 2'b00,0,0, 1,1,0, 1,CTRL_FLOW,S_RF,S_RF}
};

`endif

// ==== bench/tb_issue.sv ====
`include "issue_consts.svh"

module tb_issue
    import issue_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_issue_vectors.svh"

    localparam int TIMEOUT_CYCLES = N_ROWS + 20;

    // --------------------------------------------------
    // dut signals
    // --------------------------------------------------
    logic                                clk_i = 1'b0;
    logic                                rst_ni;
    logic                                flush_i;
    logic                                issue_valid_i;
    logic                                issue_ack_o;
    fu_e                                 issue_fu_i;
    fu_op_e                              issue_op_i;
    reg_addr_t                           issue_rs1_i;
    reg_addr_t                           issue_rs2_i;
    reg_addr_t                           issue_rd_i;
    xlen_t                               issue_imm_i;
    xlen_t                               issue_pc_i;
    trans_id_t                           issue_trans_id_i;
    logic                                issue_use_pc_i;
    logic                                issue_use_imm_i;
    logic                                issue_use_zimm_i;
    logic                                issue_ex_valid_i;
    reg_addr_t                           sb_rs1_addr_o;
    reg_addr_t                           sb_rs2_addr_o;
    xlen_t                               sb_rs1_data_i;
    logic                                sb_rs1_valid_i;
    xlen_t                               sb_rs2_data_i;
    logic                                sb_rs2_valid_i;
    fu_e [`ISSUE_NR_REGS-1:0]            rd_clobber_i;
    logic [`ISSUE_NR_COMMIT-1:0]         commit_we_i;
    reg_addr_t [`ISSUE_NR_COMMIT-1:0]    commit_waddr_i;
    xlen_t [`ISSUE_NR_COMMIT-1:0]        commit_wdata_i;
    logic                                flu_ready_i;
    logic                                lsu_ready_i;
    xlen_t                               operand_a_o;
    xlen_t                               operand_b_o;
    xlen_t                               imm_o;
    xlen_t                               pc_o;
    fu_e                                 fu_o;
    fu_op_e                              operator_o;
    trans_id_t                           trans_id_o;
    reg_addr_t                           rd_o;
    logic                                alu_valid_o;
    logic                                branch_valid_o;
    logic                                lsu_valid_o;
    logic                                mult_valid_o;
    logic                                csr_valid_o;

    // reference state
    xlen_t       shadow [`ISSUE_NR_REGS];
    logic [31:0] lcg_state = 32'hfd9a14cd;
    int unsigned cycle_cnt = 0;
    int unsigned error_cnt = 0;
    // expectations of the row now in the execute register
    row_t        prev_row;
    logic        have_prev;
    xlen_t       exp_a;
    xlen_t       exp_b;
    xlen_t       exp_imm;
    xlen_t       exp_pc;
    trans_id_t   exp_tid;

    issue_read_operands i_dut (.*);

    always #20 clk_i = ~clk_i;

    // run limit
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: run took more than %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation did not finish in time");
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic xlen_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    // value an operand should carry for a given source
    function automatic xlen_t pick_operand(input src_e src, input xlen_t rf_val,
                                           input xlen_t fwd_val, input reg_addr_t rs1);
        case (src)
            S_FWD:   return fwd_val;
            S_PC:    return issue_pc_i;
            S_ZIMM:  return xlen_t'(rs1);
            S_IMM:   return issue_imm_i;
            default: return rf_val;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            error_cnt++;
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // replay the commit writes of the last edge in port order so port 1 wins
    task automatic apply_commit();
        for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
            if (commit_we_i[p] && commit_waddr_i[p] != '0) begin
                shadow[commit_waddr_i[p]] = commit_wdata_i[p];
            end
        end
    endtask

    task automatic drive_row(input int idx);
        row_t r;
        r = VECTORS[idx];
        issue_valid_i    = r.valid;
        issue_fu_i       = r.fu;
        issue_op_i       = r.op;
        issue_rs1_i      = r.rs1;
        issue_rs2_i      = r.rs2;
        issue_rd_i       = r.rd;
        issue_use_pc_i   = r.use_pc;
        issue_use_imm_i  = r.use_imm;
        issue_use_zimm_i = r.use_zimm;
        issue_ex_valid_i = r.ex;
        issue_imm_i      = rand_word();
        issue_pc_i       = 64'h8000_0000 + 64'(idx) * 4;
        issue_trans_id_i = trans_id_t'(idx);
        sb_rs1_valid_i   = r.sb1_valid;
        sb_rs2_valid_i   = r.sb2_valid;
        sb_rs1_data_i    = rand_word();
        sb_rs2_data_i    = rand_word();
        // only the three registers of interest have a writer
        for (int k = 0; k < `ISSUE_NR_REGS; k++) begin
            rd_clobber_i[k] = NONE;
        end
        rd_clobber_i[r.rd]  = r.clob_rd;
        rd_clobber_i[r.rs1] = r.clob_rs1;
        rd_clobber_i[r.rs2] = r.clob_rs2;
        commit_we_i       = r.commit_en;
        commit_waddr_i[0] = r.commit_addr0;
        commit_waddr_i[1] = r.commit_addr1;
        commit_wdata_i[0] = rand_word();
        commit_wdata_i[1] = rand_word();
        flu_ready_i       = r.flu_ready;
        lsu_ready_i       = r.lsu_ready;
        flush_i           = r.flush;
        // expected execute register contents
        exp_a   = pick_operand(r.exp_a, shadow[r.rs1], sb_rs1_data_i, r.rs1);
        exp_b   = pick_operand(r.exp_b, shadow[r.rs2], sb_rs2_data_i, r.rs1);
        exp_imm = issue_imm_i;
        exp_pc  = issue_pc_i;
        exp_tid = issue_trans_id_i;
    endtask

    // unit pulses are checked every cycle and the payload only behind an acceptance
    task automatic check_outputs(input row_t r);
        check_value("alu_valid_o", alu_valid_o, r.exp_pulse == ALU);
        check_value("branch_valid_o", branch_valid_o, r.exp_pulse == CTRL_FLOW);
        check_value("lsu_valid_o", lsu_valid_o, r.exp_pulse inside {LOAD, STORE});
        check_value("mult_valid_o", mult_valid_o, r.exp_pulse == MULT);
        check_value("csr_valid_o", csr_valid_o, r.exp_pulse == CSR);
        if (r.exp_ack) begin
            check_value("operand_a_o", operand_a_o, exp_a);
            check_value("operand_b_o", operand_b_o, exp_b);
            check_value("imm_o", imm_o, exp_imm);
            check_value("pc_o", pc_o, exp_pc);
            check_value("fu_o", fu_o, r.fu);
            check_value("operator_o", operator_o, r.op);
            check_value("trans_id_o", trans_id_o, exp_tid);
            check_value("rd_o", rd_o, r.rd);
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        issue_valid_i    = 1'b0;
        issue_fu_i       = NONE;
        issue_op_i       = ADD;
        issue_rs1_i      = '0;
        issue_rs2_i      = '0;
        issue_rd_i       = '0;
        issue_imm_i      = '0;
        issue_pc_i       = '0;
        issue_trans_id_i = '0;
        issue_use_pc_i   = 1'b0;
        issue_use_imm_i  = 1'b0;
        issue_use_zimm_i = 1'b0;
        issue_ex_valid_i = 1'b0;
        sb_rs1_data_i    = '0;
        sb_rs1_valid_i   = 1'b0;
        sb_rs2_data_i    = '0;
        sb_rs2_valid_i   = 1'b0;
        rd_clobber_i     = '0;
        commit_we_i      = '0;
        commit_waddr_i   = '0;
        commit_wdata_i   = '0;
        flu_ready_i      = 1'b1;
        lsu_ready_i      = 1'b1;
        have_prev        = 1'b0;
        for (int k = 0; k < `ISSUE_NR_REGS; k++) begin
            shadow[k] = '0;
        end

        repeat (2) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        // execute register straight out of reset
        check_value("alu_valid_o", alu_valid_o, 1'b0);
        check_value("mult_valid_o", mult_valid_o, 1'b0);
        check_value("fu_o", fu_o, NONE);
        check_value("operator_o", operator_o, ADD);
        check_value("operand_a_o", operand_a_o, '0);

        for (int i = 0; i < N_ROWS; i++) begin
            @(posedge clk_i);
            #2;
            if (have_prev) begin
                check_outputs(prev_row);
            end
            apply_commit();
            drive_row(i);
            prev_row  = VECTORS[i];
            have_prev = 1'b1;
            // ack settles well before the next edge
            #30;
            check_value("sb_rs1_addr_o", sb_rs1_addr_o, VECTORS[i].rs1);
            check_value("sb_rs2_addr_o", sb_rs2_addr_o, VECTORS[i].rs2);
            check_value("issue_ack_o", issue_ack_o, VECTORS[i].exp_ack);
        end

        @(posedge clk_i);
        #2;
        check_outputs(prev_row);

        if (error_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+rtl
+incdir+bench
rtl/issue_pkg.sv
rtl/int_regfile.sv
rtl/issue_ctrl.sv
rtl/operand_select.sv
rtl/issue_read_operands.sv
bench/tb_issue.sv

// ==== Bender.yml ====
package:
  name: issue_read_operands

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/issue_pkg.sv
      - rtl/int_regfile.sv
      - rtl/issue_ctrl.sv
      - rtl/operand_select.sv
      - rtl/issue_read_operands.sv

  - target: test
    include_dirs:
      - rtl
      - bench
    files:
      - bench/tb_issue.sv
